// File: Makefile
VERILATOR ?= verilator
SEED      ?= 8
OBJ_DIR   ?= obj_dir
TOP       := core_tb

SRCS := $(shell grep -v '^+' files.f) verilog/rv_core_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SRCS)
	$(VERILATOR) --binary -j 0 --top-module $(TOP) -f files.f -GSEED=$(SEED) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/regfile.sv
verilog/hazard_unit.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem_access.sv
verilog/core.sv
testbench/core_tb_mem.sv
testbench/core_tb.sv

// File: testbench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module core_tb;

    parameter int unsigned SEED = 8;
    localparam int NUM_TESTS = 5;
    localparam int PROG_LEN = 12;
    localparam int TIMEOUT = 4000;

    logic                clk = 1'b0;
    logic                rst = 1'b0;
    int unsigned         stall_pct = 0;
    logic                iready_n;
    logic                dready_n;
    logic                dbusy;
    logic [`RV_XLEN-1:0] idata;
    logic [`RV_XLEN-1:0] iaddr;
    logic [`RV_XLEN-1:0] daddr;
    logic [1:0]          dsize;
    logic                dreq;
    logic                dwrite;
    wire  [`RV_XLEN-1:0] ddata;

    string       names [NUM_TESTS];
    logic [31:0] progs [NUM_TESTS][PROG_LEN];
    logic [31:0] res_addr [NUM_TESTS];
    logic [31:0] exp_val [NUM_TESTS];
    bit          chk_first [NUM_TESTS];
    logic [31:0] first_addr [NUM_TESTS];
    logic [31:0] first_data [NUM_TESTS];

    always #2 clk = ~clk;

    core core_inst (
        .clk(clk), .rst(rst), .iready_n(iready_n), .dready_n(dready_n), .dbusy(dbusy),
        .idata(idata), .iaddr(iaddr), .daddr(daddr), .dsize(dsize), .dreq(dreq),
        .dwrite(dwrite), .ddata(ddata)
    );

    core_tb_mem mem_inst (
        .clk(clk), .rst(rst), .stall_pct(stall_pct), .iaddr(iaddr), .idata(idata),
        .iready_n(iready_n), .daddr(daddr), .dreq(dreq), .dwrite(dwrite), .ddata(ddata),
        .dready_n(dready_n), .dbusy(dbusy)
    );

    function automatic logic [31:0] enc_imm(input logic [2:0] f3, input int rd, input int rs1,
                                            input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_reg(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], `RV_OP_LUI};
    endfunction

    function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], `RV_F3_WORD, rd[4:0], `RV_OP_LOAD};
    endfunction

    function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
    endfunction

    task automatic fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                progs[t][i] = enc_jal(0, 0);
            end
            chk_first[t] = 1'b0;
        end
        // immediate chain where x0 must ignore the write
        names[0] = "imm_arith";
        progs[0][0] = enc_lui(1, 32'h12345);
        progs[0][1] = enc_imm(`RV_F3_ADD, 1, 1, 32'h678);
        progs[0][2] = enc_imm(`RV_F3_AND, 2, 1, 32'h0ff);
        progs[0][3] = enc_imm(`RV_F3_OR, 2, 2, 32'h700);
        progs[0][4] = enc_imm(`RV_F3_XOR, 2, 2, -1);
        progs[0][5] = enc_imm(`RV_F3_SLT, 3, 2, 0);
        progs[0][6] = enc_imm(`RV_F3_ADD, 0, 0, 5);
        progs[0][7] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 4, 2, 3);
        progs[0][8] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 4, 4, 0);
        progs[0][9] = enc_sw(4, 0, 32'h100);
        res_addr[0] = 32'h100;
        exp_val[0] = (((32'h12345678 & 32'hff) | 32'h700) ^ 32'hffff_ffff) + 32'd1;
        // back-to-back register dependences
        names[1] = "reg_arith";
        progs[1][0] = enc_imm(`RV_F3_ADD, 1, 0, 100);
        progs[1][1] = enc_imm(`RV_F3_ADD, 2, 0, -7);
        progs[1][2] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 3, 1, 2);
        progs[1][3] = enc_reg(`RV_F7_SUB, `RV_F3_ADD, 4, 3, 2);
        progs[1][4] = enc_reg(`RV_F7_BASE, `RV_F3_AND, 5, 4, 3);
        progs[1][5] = enc_reg(`RV_F7_BASE, `RV_F3_OR, 6, 5, 2);
        progs[1][6] = enc_reg(`RV_F7_BASE, `RV_F3_XOR, 7, 6, 1);
        progs[1][7] = enc_reg(`RV_F7_BASE, `RV_F3_SLT, 8, 7, 0);
        progs[1][8] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 9, 7, 8);
        progs[1][9] = enc_sw(9, 0, 32'h104);
        res_addr[1] = 32'h104;
        exp_val[1] = (((32'd100 & 32'd93) | 32'hffff_fff9) ^ 32'd100) + 32'd1;
        // store, load right after, then use
        names[2] = "load_use";
        progs[2][0] = enc_imm(`RV_F3_ADD, 1, 0, 1234);
        progs[2][1] = enc_imm(`RV_F3_ADD, 2, 0, 32'h80);
        progs[2][2] = enc_imm(`RV_F3_ADD, 5, 0, 55);
        progs[2][3] = enc_sw(1, 2, 8);
        progs[2][4] = enc_lw(3, 2, 8);
        progs[2][5] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 4, 3, 5);
        progs[2][6] = enc_sw(4, 0, 32'h108);
        res_addr[2] = 32'h108;
        exp_val[2] = 32'd1234 + 32'd55;
        chk_first[2] = 1'b1;
        first_addr[2] = 32'h88;
        first_data[2] = 32'd1234;
        // words after a taken branch poison the result
        names[3] = "branches";
        progs[3][0] = enc_imm(`RV_F3_ADD, 1, 0, 5);
        progs[3][1] = enc_imm(`RV_F3_ADD, 2, 0, 5);
        progs[3][2] = enc_branch(`RV_F3_BEQ, 1, 2, 8);
        progs[3][3] = enc_imm(`RV_F3_ADD, 1, 1, 100);
        progs[3][4] = enc_branch(`RV_F3_BNE, 1, 2, 8);
        progs[3][5] = enc_imm(`RV_F3_ADD, 3, 0, 7);
        progs[3][6] = enc_imm(`RV_F3_ADD, 2, 2, 1);
        progs[3][7] = enc_branch(`RV_F3_BNE, 1, 2, 8);
        progs[3][8] = enc_imm(`RV_F3_ADD, 3, 3, 200);
        progs[3][9] = enc_reg(`RV_F7_BASE, `RV_F3_ADD, 4, 1, 3);
        progs[3][10] = enc_sw(4, 0, 32'h10c);
        res_addr[3] = 32'h10c;
        exp_val[3] = 32'd5 + 32'd7;
        // link value of the JAL at index 1
        names[4] = "jal_link";
        progs[4][0] = enc_imm(`RV_F3_ADD, 1, 0, 3);
        progs[4][1] = enc_jal(5, 8);
        progs[4][2] = enc_imm(`RV_F3_ADD, 5, 0, 99);
        progs[4][3] = enc_sw(5, 0, 32'h110);
        res_addr[4] = 32'h110;
        exp_val[4] = 32'd1 * 32'd4 + 32'd4;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "check failed");
        end
    endtask

    task automatic run_test(input int t);
        int          cycles;
        bit          found;
        bit          seen_first;
        logic [31:0] act;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        cycles = 0;
        found = 1'b0;
        seen_first = 1'b0;
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_inst.imem[i] = (i < PROG_LEN) ? progs[t][i] : enc_jal(0, 0);
        end
        repeat (9) @(posedge clk);
        // bus state while the core is held in reset
        @(negedge clk);
        check({names[t], " reset iaddr"}, `RV_RESET_PC, iaddr);
        check({names[t], " reset dreq"}, 32'd0, dreq);
        check({names[t], " reset dwrite"}, 32'd0, dwrite);
        @(posedge clk);
        rst <= 1'b1;
        while (!found) begin
            @(negedge clk);
            if (dreq === 1'b1) begin
                check({names[t], " dsize"}, `RV_DSIZE_WORD, dsize);
            end
            if (dreq === 1'b1 && dwrite === 1'b1) begin
                if (!seen_first) begin
                    seen_first = 1'b1;
                    st_addr = daddr;
                    st_data = ddata;
                end
                if (daddr == res_addr[t]) begin
                    found = 1'b1;
                    act = ddata;
                end
            end
            cycles++;
            if (!found && cycles > TIMEOUT) begin
                $display("result store of test %s never appeared on the data bus", names[t]);
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
        end
        check(names[t], exp_val[t], act);
        if (chk_first[t]) begin
            check({names[t], " first store address"}, first_addr[t], st_addr);
            check({names[t], " first store data"}, first_data[t], st_data);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        fill_table();
        for (int pass = 0; pass < 2; pass++) begin
            // second pass raises the stall rates
            stall_pct = (pass == 0) ? 10 : 45;
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/core_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module core_tb_mem (
    input  logic                clk,
    input  logic                rst,
    input  int unsigned         stall_pct,
    input  logic [`RV_XLEN-1:0] iaddr,
    output logic [`RV_XLEN-1:0] idata,
    output logic                iready_n = 1'b1,
    input  logic [`RV_XLEN-1:0] daddr,
    input  logic                dreq,
    input  logic                dwrite,
    inout  wire  [`RV_XLEN-1:0] ddata,
    output logic                dready_n = 1'b1,
    output logic                dbusy = 1'b0
);

    logic [`RV_XLEN-1:0] imem [0:63];
    logic [`RV_XLEN-1:0] dmem [0:255];

    // instruction word valid in the same cycle as iaddr
    assign idata = imem[iaddr[7:2]];

    assign ddata = (dreq === 1'b1 && dwrite === 1'b0) ? dmem[daddr[9:2]] : {`RV_XLEN{1'bz}};

    // random not-ready and busy levels
    always @(posedge clk) begin
        iready_n <= ($urandom % 100) < stall_pct;
        dready_n <= ($urandom % 100) < stall_pct;
        dbusy    <= ($urandom % 100) < (stall_pct / 2);
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= '0;
            end
        end else if (dreq === 1'b1 && dwrite === 1'b1 && !dbusy) begin
            dmem[daddr[9:2]] <= ddata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module core import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                iready_n,
    input  logic                dready_n,
    input  logic                dbusy,
    input  logic [`RV_XLEN-1:0] idata,
    output logic [`RV_XLEN-1:0] iaddr,
    output logic [`RV_XLEN-1:0] daddr,
    output logic [1:0]          dsize,
    output logic                dreq,
    output logic                dwrite,
    inout  wire  [`RV_XLEN-1:0] ddata
);

    logic                    stall;
    logic                    hold_front;
    logic                    bubble_ex;
    logic                    flush_front;
    logic                    redirect;
    logic [`RV_XLEN-1:0]     redirect_pc;
    logic                    write_hold;
    logic [`RV_XLEN-1:0]     instr;
    logic [`RV_XLEN-1:0]     if_pc;
    logic [`RV_XLEN-1:0]     if_pc_plus4;
    logic                    if_valid;
    logic [`RV_REG_BITS-1:0] ra1;
    logic [`RV_REG_BITS-1:0] ra2;
    logic [`RV_XLEN-1:0]     rd1;
    logic [`RV_XLEN-1:0]     rd2;
    id_ex_t                  id_ex;
    ex_mem_t                 ex_mem;
    mem_wb_t                 mem_wb;
    logic                    wb_we;
    logic [`RV_XLEN-1:0]     wb_data;

    assign stall = iready_n || (dready_n && ex_mem.valid && ex_mem.load) || dbusy || write_hold;

    fetch fetch_inst (
        .clk(clk), .rst(rst), .stall(stall), .hold_front(hold_front),
        .flush_front(flush_front), .redirect(redirect), .redirect_pc(redirect_pc),
        .idata(idata), .iaddr(iaddr), .instr(instr), .pc(if_pc),
        .pc_plus4(if_pc_plus4), .if_valid(if_valid)
    );

    decode decode_inst (
        .clk(clk), .rst(rst), .stall(stall), .bubble_ex(bubble_ex),
        .flush_front(flush_front), .instr(instr), .pc(if_pc), .pc_plus4(if_pc_plus4),
        .if_valid(if_valid), .rd1(rd1), .rd2(rd2), .ra1(ra1), .ra2(ra2), .id_ex(id_ex)
    );

    execute execute_inst (
        .clk(clk), .rst(rst), .stall(stall), .flush_front(flush_front),
        .id_ex(id_ex), .ex_mem(ex_mem)
    );

    mem_access mem_access_inst (
        .clk(clk), .rst(rst), .stall(stall), .ex_mem(ex_mem),
        .dready_n(dready_n), .dbusy(dbusy), .daddr(daddr), .dsize(dsize),
        .dreq(dreq), .dwrite(dwrite), .ddata(ddata), .write_hold(write_hold),
        .redirect(redirect), .redirect_pc(redirect_pc), .mem_wb(mem_wb)
    );

    hazard_unit hazard_unit_inst (
        .rs1(ra1), .rs2(ra2), .ex_entry(id_ex), .mem_entry(ex_mem),
        .redirect(redirect), .hold_front(hold_front), .bubble_ex(bubble_ex),
        .flush_front(flush_front)
    );

    // write only on the cycle the entry leaves WB
    assign wb_we = mem_wb.valid && mem_wb.reg_write && !stall;

    always_comb begin
        case (mem_wb.wb_sel)
            WB_MEM:  wb_data = mem_wb.load_data;
            WB_PC4:  wb_data = mem_wb.pc_plus4;
            default: wb_data = mem_wb.alu_result;
        endcase
    end

    regfile regfile_inst (
        .clk(clk), .rst(rst), .we(wb_we), .wa(mem_wb.rd), .ra1(ra1), .ra2(ra2),
        .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

endmodule

`default_nettype wire

// File: verilog/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module decode import rv_core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    bubble_ex,
    input  logic                    flush_front,
    input  logic [`RV_XLEN-1:0]     instr,
    input  logic [`RV_XLEN-1:0]     pc,
    input  logic [`RV_XLEN-1:0]     pc_plus4,
    input  logic                    if_valid,
    input  logic [`RV_XLEN-1:0]     rd1,
    input  logic [`RV_XLEN-1:0]     rd2,
    output logic [`RV_REG_BITS-1:0] ra1,
    output logic [`RV_REG_BITS-1:0] ra2,
    output id_ex_t                  id_ex
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    alu_op_t             f3_op;
    logic                f3_ok;
    logic                known;
    id_ex_t              entry;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign ra1    = instr[19:15];
    assign ra2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by register and immediate forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            `RV_F3_ADD: f3_op = ALU_ADD;
            `RV_F3_SLT: f3_op = ALU_SLT;
            `RV_F3_XOR: f3_op = ALU_XOR;
            `RV_F3_OR:  f3_op = ALU_OR;
            `RV_F3_AND: f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        entry          = '0;
        entry.pc       = pc;
        entry.pc_plus4 = pc_plus4;
        entry.rs1_val  = rd1;
        entry.rs2_val  = rd2;
        entry.rd       = instr[11:7];
        entry.alu_op   = ALU_ADD;
        entry.wb_sel   = WB_ALU;
        known          = 1'b1;
        case (opcode)
            `RV_OP_LUI: begin
                entry.imm         = imm_u;
                entry.alu_op      = ALU_PASS_B;
                entry.alu_src_imm = 1'b1;
                entry.reg_write   = 1'b1;
            end
            `RV_OP_IMM: begin
                entry.imm         = imm_i;
                entry.alu_op      = f3_op;
                entry.alu_src_imm = 1'b1;
                entry.reg_write   = 1'b1;
                known             = f3_ok;
            end
            `RV_OP_REG: begin
                entry.alu_op    = (funct7 == `RV_F7_SUB) ? ALU_SUB : f3_op;
                entry.reg_write = 1'b1;
                known = f3_ok && (funct7 == `RV_F7_BASE ||
                                  (funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD));
            end
            `RV_OP_LOAD: begin
                entry.imm         = imm_i;
                entry.alu_src_imm = 1'b1;
                entry.reg_write   = 1'b1;
                entry.wb_sel      = WB_MEM;
                entry.load        = 1'b1;
                known             = (funct3 == `RV_F3_WORD);
            end
            `RV_OP_STORE: begin
                entry.imm         = imm_s;
                entry.alu_src_imm = 1'b1;
                entry.store       = 1'b1;
                known             = (funct3 == `RV_F3_WORD);
            end
            `RV_OP_BRANCH: begin
                entry.imm = imm_b;
                entry.beq = (funct3 == `RV_F3_BEQ);
                entry.bne = (funct3 == `RV_F3_BNE);
                known     = entry.beq || entry.bne;
            end
            `RV_OP_JAL: begin
                entry.imm       = imm_j;
                entry.reg_write = 1'b1;
                entry.wb_sel    = WB_PC4;
                entry.jump      = 1'b1;
            end
            default: known = 1'b0;
        endcase
        entry.valid = if_valid && known && !flush_front && !bubble_ex;
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= entry;
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst)
        id_ex.valid |-> !(id_ex.load && id_ex.store))
        else $error("entry marked as both load and store");

endmodule

`default_nettype wire

// File: verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module execute import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush_front,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic                equal;
    ex_mem_t             result;

    assign op_b  = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_val;
    assign equal = (id_ex.rs1_val == id_ex.rs2_val);

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_y = id_ex.rs1_val + op_b;
            ALU_SUB: alu_y = id_ex.rs1_val - op_b;
            ALU_AND: alu_y = id_ex.rs1_val & op_b;
            ALU_OR:  alu_y = id_ex.rs1_val | op_b;
            ALU_XOR: alu_y = id_ex.rs1_val ^ op_b;
            ALU_SLT: alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(id_ex.rs1_val) < $signed(op_b)};
            default: alu_y = op_b;
        endcase
    end

    always_comb begin
        result.alu_result    = alu_y;
        result.store_data    = id_ex.rs2_val;
        result.branch_target = id_ex.pc + id_ex.imm;
        result.pc_plus4      = id_ex.pc_plus4;
        result.rd            = id_ex.rd;
        result.reg_write     = id_ex.reg_write;
        result.wb_sel        = id_ex.wb_sel;
        result.load          = id_ex.load;
        result.store         = id_ex.store;
        result.take_branch   = id_ex.jump || (id_ex.beq && equal) || (id_ex.bne && !equal);
        // younger than a redirecting branch in MEM
        result.valid         = id_ex.valid && !flush_front;
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem <= result;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                hold_front,
    input  logic                flush_front,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    input  logic [`RV_XLEN-1:0] idata,
    output logic [`RV_XLEN-1:0] iaddr,
    output logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pc_plus4,
    output logic                if_valid
);

    logic [`RV_XLEN-1:0] fetch_pc;
    logic [`RV_XLEN-1:0] seq_pc;

    assign seq_pc = fetch_pc + `RV_XLEN'd4;
    assign iaddr  = fetch_pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_pc <= `RV_RESET_PC;
            instr    <= `RV_NOP;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if (redirect) begin
                fetch_pc <= redirect_pc;
            end else if (!hold_front) begin
                fetch_pc <= seq_pc;
            end
            // IF/ID register
            if (flush_front) begin
                instr    <= `RV_NOP;
                if_valid <= 1'b0;
            end else if (!hold_front) begin
                instr    <= idata;
                pc       <= fetch_pc;
                pc_plus4 <= seq_pc;
                if_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module hazard_unit import rv_core_pkg::*; (
    input  logic [`RV_REG_BITS-1:0] rs1,
    input  logic [`RV_REG_BITS-1:0] rs2,
    input  id_ex_t                  ex_entry,
    input  ex_mem_t                 mem_entry,
    input  logic                    redirect,
    output logic                    hold_front,
    output logic                    bubble_ex,
    output logic                    flush_front
);

    logic ex_hit;
    logic mem_hit;

    function automatic logic dest_hit(
        input logic                    writes,
        input logic [`RV_REG_BITS-1:0] rd,
        input logic [`RV_REG_BITS-1:0] a,
        input logic [`RV_REG_BITS-1:0] b
    );
        return writes && (rd != '0) && (rd == a || rd == b);
    endfunction

    assign ex_hit  = dest_hit(ex_entry.valid && ex_entry.reg_write, ex_entry.rd, rs1, rs2);
    assign mem_hit = dest_hit(mem_entry.valid && mem_entry.reg_write, mem_entry.rd, rs1, rs2);

    // redirect wins, the waiting instruction is flushed anyway
    assign flush_front = redirect;
    assign hold_front  = (ex_hit || mem_hit) && !redirect;
    assign bubble_ex   = hold_front;

    always_comb begin
        a_hold_vs_flush: assert (!(hold_front && flush_front))
            else $error("front end held and flushed together");
    end

endmodule

`default_nettype wire

// File: verilog/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module mem_access import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  ex_mem_t             ex_mem,
    input  logic                dready_n,
    input  logic                dbusy,
    output logic [`RV_XLEN-1:0] daddr,
    output logic [1:0]          dsize,
    output logic                dreq,
    output logic                dwrite,
    inout  wire  [`RV_XLEN-1:0] ddata,
    output logic                write_hold,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,
    output mem_wb_t             mem_wb
);

    logic store_in_mem;
    logic hold_done;

    assign store_in_mem = ex_mem.valid && ex_mem.store;

    assign dreq   = ex_mem.valid && (ex_mem.load || ex_mem.store);
    assign dwrite = store_in_mem;
    assign daddr  = ex_mem.alu_result;
    assign dsize  = `RV_DSIZE_WORD;
    assign ddata  = (dreq && dwrite) ? ex_mem.store_data : {`RV_XLEN{1'bz}};

    // one extra cycle on the first cycle of each store
    assign write_hold = store_in_mem && !hold_done;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hold_done <= 1'b0;
        end else if (!stall) begin
            hold_done <= 1'b0;
        end else if (write_hold) begin
            hold_done <= 1'b1;
        end
    end

    assign redirect    = ex_mem.valid && ex_mem.take_branch;
    assign redirect_pc = ex_mem.branch_target;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_wb.valid <= 1'b0;
        end else if (!stall) begin
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= ddata;
            mem_wb.pc_plus4   <= ex_mem.pc_plus4;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.wb_sel     <= ex_mem.wb_sel;
            mem_wb.valid      <= ex_mem.valid;
        end
    end

    a_dwrite_req: assert property (@(posedge clk) disable iff (!rst) dwrite |-> dreq)
        else $error("dwrite without dreq");

    // an access leaves MEM only once the bus has answered
    a_access_done: assert property (@(posedge clk) disable iff (!rst)
        dreq && !stall |-> !dbusy && (dwrite || !dready_n))
        else $error("memory access left MEM before the bus answered");

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic [`RV_REG_BITS-1:0] wa,
    input  logic [`RV_REG_BITS-1:0] ra1,
    input  logic [`RV_REG_BITS-1:0] ra2,
    input  logic [`RV_XLEN-1:0]     wd,
    output logic [`RV_XLEN-1:0]     rd1,
    output logic [`RV_XLEN-1:0]     rd2
);

    logic [`RV_XLEN-1:0] regs [0:(1 << `RV_REG_BITS)-1];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < (1 << `RV_REG_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so write-back needs no hazard check
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

    a_wa_known: assert property (@(posedge clk) disable iff (!rst) we |-> !$isunknown(wa))
        else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: verilog/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

`define RV_XLEN         32
`define RV_REG_BITS     5
`define RV_RESET_PC     32'h0000_0000
// addi x0, x0, 0
`define RV_NOP          32'h0000_0013
`define RV_DSIZE_WORD   2'b10

// major opcodes
`define RV_OP_LUI       7'b0110111
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111

// funct3 codes
`define RV_F3_ADD       3'b000
`define RV_F3_SLT       3'b010
`define RV_F3_XOR       3'b100
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_WORD      3'b010
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001

// funct7 codes
`define RV_F7_BASE      7'b0000000
`define RV_F7_SUB       7'b0100000

// alu operation encodings
`define RV_ALU_ADD      3'd0
`define RV_ALU_SUB      3'd1
`define RV_ALU_AND      3'd2
`define RV_ALU_OR       3'd3
`define RV_ALU_XOR      3'd4
`define RV_ALU_SLT      3'd5
`define RV_ALU_PASS_B   3'd6

`endif

// File: verilog/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = `RV_ALU_ADD,
        ALU_SUB    = `RV_ALU_SUB,
        ALU_AND    = `RV_ALU_AND,
        ALU_OR     = `RV_ALU_OR,
        ALU_XOR    = `RV_ALU_XOR,
        ALU_SLT    = `RV_ALU_SLT,
        ALU_PASS_B = `RV_ALU_PASS_B
    } alu_op_t;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]     pc;
        logic [`RV_XLEN-1:0]     pc_plus4;
        logic [`RV_XLEN-1:0]     rs1_val;
        logic [`RV_XLEN-1:0]     rs2_val;
        logic [`RV_XLEN-1:0]     imm;
        logic [`RV_REG_BITS-1:0] rd;
        logic                    reg_write;
        alu_op_t                 alu_op;
        logic                    alu_src_imm;
        wb_sel_t                 wb_sel;
        logic                    load;
        logic                    store;
        logic                    beq;
        logic                    bne;
        logic                    jump;
        logic                    valid;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]     alu_result;
        logic [`RV_XLEN-1:0]     store_data;
        logic [`RV_XLEN-1:0]     branch_target;
        logic [`RV_XLEN-1:0]     pc_plus4;
        logic [`RV_REG_BITS-1:0] rd;
        logic                    reg_write;
        wb_sel_t                 wb_sel;
        logic                    load;
        logic                    store;
        logic                    take_branch;
        logic                    valid;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]     alu_result;
        logic [`RV_XLEN-1:0]     load_data;
        logic [`RV_XLEN-1:0]     pc_plus4;
        logic [`RV_REG_BITS-1:0] rd;
        logic                    reg_write;
        wb_sel_t                 wb_sel;
        logic                    valid;
    } mem_wb_t;

endpackage

`default_nettype wire
